// ==== source/irq_pkg.sv ====
// Interrupt numbering, implemented line mask, priority order and the
// arbitration structs shared by the interrupt controller stages

package irq_pkg;

  // ----------------------------------------------------------------------
  // Interrupt numbering
  // ----------------------------------------------------------------------

  // One line per machine-mode interrupt source
  localparam int unsigned NUM_IRQ  = 32;
  // Enough bits to name any of the 32 lines
  localparam int unsigned IRQ_ID_W = 5;

  // Implemented lines: 31..16 platform, 11 external, 7 timer, 3 software
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hffff_0888;

  // ----------------------------------------------------------------------
  // Priority order
  // ----------------------------------------------------------------------

  // Number of implemented lines taking part in arbitration
  localparam int unsigned NUM_PRIO = 19;

  // Entry 0 is the highest priority, entry NUM_PRIO-1 the lowest
  // Concatenation lists lowest first, so 31 lands on entry 0
  localparam logic [NUM_PRIO-1:0][IRQ_ID_W-1:0] PRIO_ORDER = {
    5'd7,  5'd3,  5'd11,
    5'd16, 5'd17, 5'd18, 5'd19, 5'd20, 5'd21, 5'd22, 5'd23,
    5'd24, 5'd25, 5'd26, 5'd27, 5'd28, 5'd29, 5'd30, 5'd31
  };

  // ----------------------------------------------------------------------
  // Types
  // ----------------------------------------------------------------------

  // One bit per line, used for irq_i, mip and mie
  typedef logic [NUM_IRQ-1:0]  irq_vec_t;
  // Interrupt number as handed to the core
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  // Enable state owned by the core CSRs
  typedef struct packed {
    irq_vec_t mie;
    logic     mstatus_mie;
  } irq_enable_t;

  // Arbitration result, registered in the arbiter
  typedef struct packed {
    logic    valid;
    irq_id_t id;
  } irq_winner_t;

endpackage : irq_pkg

// ==== source/pm_pkg.sv ====
// Power management definitions for the WFI sleep controller

package pm_pkg;

  // ----------------------------------------------------------------------
  // Sleep controller states
  // ----------------------------------------------------------------------

  // RUN        core executing
  // WAIT_IDLE  WFI retired, pipeline still draining
  // SLEEP      core_sleep_o asserted
  typedef enum logic [1:0] {
    RUN       = 2'd0,
    WAIT_IDLE = 2'd1,
    SLEEP     = 2'd2
  } sleep_state_e;

  // ----------------------------------------------------------------------
  // Core status
  // ----------------------------------------------------------------------

  // Status bits reported by the core pipeline
  typedef struct packed {
    // Single-cycle pulse when a WFI retires
    logic wfi_retired;
    // No outstanding fetch and LSU not busy
    logic pipe_idle;
  } core_status_t;

endpackage : pm_pkg

// ==== source/irq_arbiter.sv ====
// Interrupt arbiter: samples irq_i into mip, masks with the enables and
// registers the fixed-priority winner for the delivery stage

module irq_arbiter
  import irq_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // External interrupt lines
  input  irq_vec_t    irq_i,
  // Core enable state (mie, mstatus.MIE)
  input  irq_enable_t enable_i,

  // CSR read value of mip
  output irq_vec_t    mip_o,
  // Registered winner to delivery
  output irq_winner_t winner_o,
  // Any pending and locally enabled line, for WFI wakeup
  output logic        pend_any_o
);

  // ----------------------------------------------------------------------
  // Signals
  // ----------------------------------------------------------------------

  irq_vec_t    mip_q;
  // mip & mie, regardless of mstatus.MIE
  irq_vec_t    pend_en;
  // Lines that may actually be delivered
  irq_vec_t    pend_deliv;
  irq_winner_t winner_d;
  irq_winner_t winner_q;

  // ----------------------------------------------------------------------
  // Sampling
  // ----------------------------------------------------------------------

  // Reserved lines never reach mip
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & VALID_IRQ_MASK;
    end
  end

  assign mip_o = mip_q;

  // ----------------------------------------------------------------------
  // Enable masking
  // ----------------------------------------------------------------------

  assign pend_en = mip_q & enable_i.mie;

  // Global enable gates delivery only
  assign pend_deliv = enable_i.mstatus_mie ? pend_en : '0;

  // Wakeup ignores mstatus.MIE
  assign pend_any_o = |pend_en;

  // ----------------------------------------------------------------------
  // Priority selection
  // ----------------------------------------------------------------------

  // Walk from lowest to highest priority
  // the last hit overwrites, so the highest pending line wins
  always_comb begin
    winner_d = '0;
    for (int i = NUM_PRIO - 1; i >= 0; i--) begin
      if (pend_deliv[PRIO_ORDER[i]]) begin
        winner_d.valid = 1'b1;
        winner_d.id    = PRIO_ORDER[i];
      end
    end
  end

  // Winner register, updated every cycle
  // Delivery decides when to take it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      winner_q <= '0;
    end else begin
      winner_q <= winner_d;
    end
  end

  assign winner_o = winner_q;

endmodule : irq_arbiter

// ==== source/irq_delivery.sv ====
// Interrupt delivery: presents the winning id to the core over a
// four-phase req/ack handshake

module irq_delivery
  import irq_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // Registered winner from the arbiter
  input  irq_winner_t winner_i,

  // Core side of the handshake
  input  logic        irq_ack_i,
  output logic        irq_req_o,
  output irq_id_t     irq_id_o
);

  // ----------------------------------------------------------------------
  // Handshake FSM
  // ----------------------------------------------------------------------

  // IDLE          no request, waiting for a valid winner
  // REQ           irq_req_o high, id held, waiting for ack
  // WAIT_ACK_LOW  request dropped, waiting for the core to drop ack
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    REQ          = 2'd1,
    WAIT_ACK_LOW = 2'd2
  } dlv_state_e;

  dlv_state_e state_q;
  dlv_state_e state_d;
  irq_id_t    id_q;
  logic       take_winner;

  // New request only from IDLE with ack already low
  // Winners arriving mid-handshake are dropped, not queued
  assign take_winner = (state_q == IDLE) && winner_i.valid && !irq_ack_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (take_winner) begin
          state_d = REQ;
        end
      end
      REQ: begin
        // Drop request on the edge after ack is seen
        if (irq_ack_i) begin
          state_d = WAIT_ACK_LOW;
        end
      end
      WAIT_ACK_LOW: begin
        if (!irq_ack_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Id captured as the request rises, stable until it falls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else if (take_winner) begin
      id_q <= winner_i.id;
    end
  end

  assign irq_req_o = (state_q == REQ);
  assign irq_id_o  = id_q;

endmodule : irq_delivery

// ==== source/wfi_sleep_ctrl.sv ====
// WFI sleep controller: waits for the pipeline to drain after a WFI,
// asserts core_sleep_o and wakes on any pending enabled interrupt

module wfi_sleep_ctrl
  import pm_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  // WFI retire pulse and pipeline idle from the core
  input  core_status_t status_i,
  // mip & mie, independent of mstatus.MIE
  input  logic         pend_any_i,

  output logic         core_sleep_o
);

  // ----------------------------------------------------------------------
  // Sleep FSM
  // ----------------------------------------------------------------------

  sleep_state_e state_q;
  sleep_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN: begin
        // One-cycle pulse from the core on WFI retirement
        if (status_i.wfi_retired) begin
          state_d = WAIT_IDLE;
        end
      end
      WAIT_IDLE: begin
        // Wake wins over going to sleep
        if (pend_any_i) begin
          state_d = RUN;
        end else if (status_i.pipe_idle) begin
          state_d = SLEEP;
        end
      end
      SLEEP: begin
        if (pend_any_i) begin
          state_d = RUN;
        end
      end
      default: state_d = RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------------------
  // Output decode
  // ----------------------------------------------------------------------

  // Straight from the state register, no combinational path from inputs
  assign core_sleep_o = (state_q == SLEEP);

endmodule : wfi_sleep_ctrl

// ==== source/irq_ctrl_top.sv ====
// Machine-mode interrupt controller top: arbiter, delivery handshake and
// WFI sleep controller

module irq_ctrl_top
  import irq_pkg::*;
  import pm_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  // External interrupt lines
  input  irq_vec_t     irq_i,
  // Core enable state
  input  irq_enable_t  enable_i,
  // Core handshake ack
  input  logic         irq_ack_i,
  // Core pipeline status
  input  core_status_t status_i,

  // CSR read value
  output irq_vec_t     mip_o,
  // Delivery handshake
  output logic         irq_req_o,
  output irq_id_t      irq_id_o,
  // Sleep indication
  output logic         core_sleep_o
);

  // Arbiter to delivery
  irq_winner_t winner;
  // Arbiter to sleep controller
  logic        pend_any;

  // Stage 1, sampling and arbitration
  irq_arbiter u_irq_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .irq_i      (irq_i),
    .enable_i   (enable_i),
    .mip_o      (mip_o),
    .winner_o   (winner),
    .pend_any_o (pend_any)
  );

  // Stage 2, four-phase delivery
  irq_delivery u_irq_delivery (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .winner_i  (winner),
    .irq_ack_i (irq_ack_i),
    .irq_req_o (irq_req_o),
    .irq_id_o  (irq_id_o)
  );

  // Sleep control beside the pipeline
  wfi_sleep_ctrl u_wfi_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .status_i     (status_i),
    .pend_any_i   (pend_any),
    .core_sleep_o (core_sleep_o)
  );

endmodule : irq_ctrl_top

// ==== verif/irq_ctrl_asserts.sv ====
// Concurrent checks on the interrupt controller ports, bound into the top
// level, with a small reference model of priority, handshake and sleep

module irq_ctrl_asserts
  import irq_pkg::*;
  import pm_pkg::*;
(
  input logic         clk_i,
  input logic         rst_ni,
  input irq_vec_t     irq_i,
  input irq_enable_t  enable_i,
  input logic         irq_ack_i,
  input core_status_t status_i,
  input irq_vec_t     mip_o,
  input logic         irq_req_o,
  input irq_id_t      irq_id_o,
  input logic         core_sleep_o
);

  // Previous-cycle samples and model state
  typedef struct packed {
    irq_vec_t    irq;
    irq_winner_t pick1;
    irq_winner_t pick2;
    logic        req;
    logic        ack;
    irq_id_t     id;
    logic        sleep;
    logic        go;
    logic        wake;
    logic        armed;
  } hist_t;

  // First failing check as read by the testbench
  logic        fail_seen = 1'b0;
  string       fail_name;
  logic [31:0] fail_exp;
  logic [31:0] fail_act;

  hist_t       hist_q;
  irq_vec_t    mip_exp;
  irq_winner_t pick_now;
  logic        pend_en;
  logic        go_now;
  logic        wake_now;

  // Lines 31 down to 16, then 11, then 3, then 7
  function automatic irq_winner_t highest_pending(irq_vec_t pend);
    for (int i = 31; i >= 16; i--) begin
      if (pend[i]) return {1'b1, irq_id_t'(i)};
    end
    if (pend[11]) return {1'b1, 5'd11};
    if (pend[3]) return {1'b1, 5'd3};
    if (pend[7]) return {1'b1, 5'd7};
    return '0;
  endfunction

  task automatic note_fail(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (!fail_seen) begin
      fail_name = name;
      fail_exp  = exp;
      fail_act  = act;
      fail_seen = 1'b1;
    end
    $error("check %s failed", name);
  endtask

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  assign mip_exp  = hist_q.irq & VALID_IRQ_MASK;
  assign pend_en  = |(mip_o & enable_i.mie);
  assign pick_now = highest_pending(enable_i.mstatus_mie ? (mip_o & enable_i.mie) : '0);
  // WAIT_IDLE is armed without sleep
  assign go_now   = hist_q.armed && !core_sleep_o && status_i.pipe_idle && !pend_en;
  assign wake_now = core_sleep_o && pend_en;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q <= '0;
    end else begin
      hist_q.irq   <= irq_i;
      hist_q.pick1 <= pick_now;
      hist_q.pick2 <= hist_q.pick1;
      hist_q.req   <= irq_req_o;
      hist_q.ack   <= irq_ack_i;
      hist_q.id    <= irq_id_o;
      hist_q.sleep <= core_sleep_o;
      hist_q.go    <= go_now;
      hist_q.wake  <= wake_now;
      // A wake disarms and otherwise a retired WFI arms
      if (hist_q.armed && pend_en) begin
        hist_q.armed <= 1'b0;
      end else if (status_i.wfi_retired) begin
        hist_q.armed <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Sampling and arbitration
  // ----------------------------------------------------------------------

  a_mip_sample: assert property (@(posedge clk_i) disable iff (!rst_ni) mip_o == mip_exp)
    else note_fail("mip_sample", $sampled(mip_exp), $sampled(mip_o));
  a_mip_reserved: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (mip_o & ~VALID_IRQ_MASK) == '0)
    else note_fail("mip_reserved", 32'h0, $sampled(mip_o) & ~VALID_IRQ_MASK);
  a_req_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      irq_req_o && !hist_q.req |-> hist_q.pick2.valid)
    else note_fail("req_valid", 32'h1, $sampled(hist_q.pick2.valid));
  a_req_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
      irq_req_o && !hist_q.req |-> irq_id_o == hist_q.pick2.id)
    else note_fail("req_id", $sampled(hist_q.pick2.id), $sampled(irq_id_o));

  // ----------------------------------------------------------------------
  // Four-phase handshake
  // ----------------------------------------------------------------------

  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      hist_q.req && !hist_q.ack |-> irq_req_o && irq_id_o == hist_q.id)
    else note_fail("req_hold", {1'b1, $sampled(hist_q.id)}, {$sampled(irq_req_o),
      $sampled(irq_id_o)});
  a_req_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
      hist_q.req && hist_q.ack |-> !irq_req_o)
    else note_fail("req_fall", 32'h0, $sampled(irq_req_o));
  a_req_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
      irq_req_o && !hist_q.req |-> !hist_q.ack)
    else note_fail("req_rise", 32'h0, $sampled(hist_q.ack));

  // ----------------------------------------------------------------------
  // WFI sleep and reset
  // ----------------------------------------------------------------------

  a_sleep_enter: assert property (@(posedge clk_i) disable iff (!rst_ni)
      hist_q.go |-> core_sleep_o)
    else note_fail("sleep_enter", 32'h1, $sampled(core_sleep_o));
  a_sleep_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
      core_sleep_o && !hist_q.sleep |-> hist_q.go)
    else note_fail("sleep_cause", 32'h1, $sampled(hist_q.go));
  a_sleep_armed: assert property (@(posedge clk_i) disable iff (!rst_ni)
      core_sleep_o |-> hist_q.armed)
    else note_fail("sleep_armed", 32'h1, $sampled(hist_q.armed));
  a_sleep_wake: assert property (@(posedge clk_i) disable iff (!rst_ni)
      hist_q.wake |-> !core_sleep_o)
    else note_fail("sleep_wake", 32'h0, $sampled(core_sleep_o));
  // Outputs seen on the first edge after reset release
  a_reset: assert property (@(posedge clk_i)
      $rose(rst_ni) |-> !irq_req_o && !core_sleep_o && irq_id_o == '0)
    else note_fail("reset_values", 32'h0, {$sampled(irq_req_o), $sampled(core_sleep_o),
      $sampled(irq_id_o)});

endmodule : irq_ctrl_asserts

bind irq_ctrl_top irq_ctrl_asserts u_irq_ctrl_asserts (.*);

// ==== verif/tb_irq_ctrl.sv ====
// Testbench for the interrupt controller: LFSR random traffic, directed WFI
// rounds and a core-side ack responder; checks live in the bound assertions

module tb_irq_ctrl
  import irq_pkg::*;
  import pm_pkg::*;
();

  localparam int DRIVE_DLY    = 10;
  localparam int RAND_CYCLES  = 400;
  localparam int WFI_ROUNDS   = 8;
  // Worst case of one WFI round: settle, drain, sleep, wake, tail
  localparam int ROUND_CYCLES = 24;
  localparam int CYCLE_LIMIT  = 2 + RAND_CYCLES + WFI_ROUNDS * ROUND_CYCLES + 40;

  logic         clk_i = 1'b0;
  logic         rst_ni;
  irq_vec_t     irq_i;
  irq_enable_t  enable_i;
  logic         irq_ack_i;
  core_status_t status_i;
  irq_vec_t     mip_o;
  logic         irq_req_o;
  irq_id_t      irq_id_o;
  logic         core_sleep_o;

  logic [15:0]  lfsr_q = 16'd19153;
  int           ack_delay;
  int           cycle_count = 0;
  int           req_count;
  int           sleep_count;

  irq_ctrl_top dut0 (.*);

  always #50 clk_i = ~clk_i;

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v[i] = lfsr_q[0];
    end
  endtask

  // One clock, then the core side reacts to stable outputs
  task automatic step_cycle();
    logic [31:0] d;
    @(posedge clk_i);
    #DRIVE_DLY;
    // WFI retire is a single pulse
    status_i.wfi_retired = 1'b0;
    if (core_sleep_o) sleep_count++;
    if (irq_ack_i) begin
      if (!irq_req_o) irq_ack_i = 1'b0;
    end else if (irq_req_o) begin
      // Ack 0 to 3 cycles after the request
      if (ack_delay < 0) begin
        draw_bits(2, d);
        ack_delay = int'(d);
      end
      if (ack_delay == 0) begin
        irq_ack_i = 1'b1;
        req_count++;
      end
      ack_delay--;
    end
  endtask

  task automatic random_cycle();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] m;
    draw_bits(32, a);
    draw_bits(32, b);
    draw_bits(32, m);
    // About a quarter of the lines pending
    irq_i = a & b;
    enable_i.mie = m;
    draw_bits(2, a);
    enable_i.mstatus_mie = |a[1:0];
    draw_bits(4, a);
    status_i.wfi_retired = (a[3:0] == 4'd0);
    draw_bits(1, a);
    status_i.pipe_idle = a[0];
    step_cycle();
  endtask

  // WFI with pipe_idle low for a while, then sleep and wake on one line
  task automatic wfi_round(input int r);
    logic [31:0] v;
    irq_id_t     line;
    irq_i = '0;
    status_i.pipe_idle = 1'b0;
    repeat (3) step_cycle();
    draw_bits(32, v);
    enable_i.mie = v;
    draw_bits(1, v);
    enable_i.mstatus_mie = v[0];
    status_i.wfi_retired = 1'b1;
    step_cycle();
    draw_bits(2, v);
    repeat (v[1:0] + 1) step_cycle();
    draw_bits(4, v);
    case (r % 4)
      0: line = irq_id_t'(16 + v[3:0]);
      1: line = 5'd3;
      2: line = 5'd7;
      default: line = 5'd11;
    endcase
    enable_i.mie[line] = 1'b1;
    if (r % 3 == 2) begin
      // Wake while still in WAIT_IDLE
      irq_i[line] = 1'b1;
    end else begin
      status_i.pipe_idle = 1'b1;
      while (!core_sleep_o) step_cycle();
      repeat (2) step_cycle();
      irq_i[line] = 1'b1;
    end
    step_cycle();
    while (core_sleep_o) step_cycle();
    repeat (3) step_cycle();
    irq_i = '0;
  endtask

  initial begin
    rst_ni      = 1'b0;
    irq_i       = '0;
    enable_i    = '0;
    irq_ack_i   = 1'b0;
    status_i    = '0;
    ack_delay   = -1;
    req_count   = 0;
    sleep_count = 0;
    repeat (2) @(posedge clk_i);
    #DRIVE_DLY;
    rst_ni = 1'b1;
    repeat (RAND_CYCLES) random_cycle();
    for (int r = 0; r < WFI_ROUNDS; r++) begin
      wfi_round(r);
    end
    irq_i = '0;
    repeat (10) step_cycle();
    if (req_count == 0 || sleep_count == 0) begin
      $display("stimulus never delivered an interrupt or never put the core to sleep");
      $display("RESULT: FAIL");
      $fatal(1, "incomplete stimulus");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

  // First assertion failure ends the run
  initial begin
    wait (dut0.u_irq_ctrl_asserts.fail_seen);
    $display("ERROR %s: expected %0h, actual %0h", dut0.u_irq_ctrl_asserts.fail_name,
      dut0.u_irq_ctrl_asserts.fail_exp, dut0.u_irq_ctrl_asserts.fail_act);
    $display("RESULT: FAIL");
    $fatal(1, "assertion check failed");
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

endmodule : tb_irq_ctrl

// ==== sources.f ====
source/irq_pkg.sv
source/pm_pkg.sv
source/irq_arbiter.sv
source/irq_delivery.sv
source/wfi_sleep_ctrl.sv
source/irq_ctrl_top.sv
verif/irq_ctrl_asserts.sv
verif/tb_irq_ctrl.sv
